/* logic/qdr_cpu_pkg.sv */
// QDR CPU access package
// widths, window register map, bus and QDR command types
// shared by the register port, the memory window and the burst engine
package qdr_cpu_pkg;

  localparam int QDR_ADDR_BITS = 22;
  localparam int DATA_BITS     = 18;
  localparam int MASK_BITS     = 2;
  localparam int BURST_WIDTH   = 4;
  localparam int RESET_STRETCH = 8;

  // one beat carries two sram words
  localparam int BEAT_BITS       = 2 * DATA_BITS;
  localparam int BEAT_BE_BITS    = 2 * MASK_BITS;
  localparam int BURST_BITS      = BURST_WIDTH * DATA_BITS;
  localparam int BURST_MASK_BITS = BURST_WIDTH * MASK_BITS;
  localparam int ADDR_HI_BITS    = QDR_ADDR_BITS - 16;
  localparam int TOP_WORD_LSB    = 16 * (BURST_WIDTH - 1);
  localparam int TOP_WORD_BITS   = BURST_BITS % 16;
  localparam int WIN_DATA_BITS   = TOP_WORD_LSB + TOP_WORD_BITS;
  localparam int RST_CNT_BITS    = $clog2(RESET_STRETCH + 1);

  // memory window word offsets, bus address bits 7:1
  localparam logic [6:0] WIN_WR_CTRL  = 7'd0;
  localparam logic [6:0] WIN_RD_CTRL  = 7'd1;
  localparam logic [6:0] WIN_ADDR_LO  = 7'd2;
  localparam logic [6:0] WIN_ADDR_HI  = 7'd3;
  localparam logic [6:0] WIN_MASK     = 7'd4;
  localparam logic [6:0] WIN_WR_DATA0 = 7'd5;
  localparam logic [6:0] WIN_WR_DATA1 = 7'd6;
  localparam logic [6:0] WIN_WR_DATA2 = 7'd7;
  localparam logic [6:0] WIN_WR_DATA3 = 7'd8;
  localparam logic [6:0] WIN_RD_DATA0 = 7'd9;
  localparam logic [6:0] WIN_RD_DATA1 = 7'd10;
  localparam logic [6:0] WIN_RD_DATA2 = 7'd11;
  localparam logic [6:0] WIN_RD_DATA3 = 7'd12;

  // register port offsets
  localparam logic [6:0] REG_CTRL   = 7'd0;
  localparam logic [6:0] REG_STATUS = 7'd1;

  typedef logic [15:0]                wb_data_t;
  typedef logic [31:0]                wb_adr_t;
  typedef logic [QDR_ADDR_BITS-1:0]   qdr_addr_t;
  typedef logic [BEAT_BITS-1:0]       qdr_beat_t;
  typedef logic [BEAT_BE_BITS-1:0]    qdr_be_t;
  typedef logic [BURST_BITS-1:0]      burst_data_t;
  typedef logic [BURST_MASK_BITS-1:0] burst_mask_t;

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    logic [1:0] sel;
    wb_adr_t  adr;
    wb_data_t dat;
  } wb_req_t;

  typedef struct packed {
    qdr_addr_t   addr;
    burst_data_t data;
    burst_mask_t mask;
  } burst_req_t;

  typedef struct packed {
    qdr_addr_t addr;
    qdr_beat_t data;
    qdr_be_t   be;
    logic      addr_en;
    logic      data_en;
  } qdr_wr_cmd_t;

  typedef struct packed {
    qdr_addr_t addr;
    logic      en;
  } qdr_rd_cmd_t;

  typedef enum logic [2:0] {
    IDLE,
    WR_BEAT0,
    WR_BEAT1,
    RD_ISSUE,
    RD_WAIT
  } burst_state_t;

endpackage

/* logic/qdr_reset_ctrl.sv */
// QDR PHY reset control
// register-port slave: a CTRL write with bit 0 set starts a stretched
// reset pulse to the PHY; reads return phy ready and reset-active status
`timescale 1ns/1ps

module qdr_reset_ctrl (
  input  logic                  qdr_clk_i,
  input  logic                  wb_rst_i,
  input  qdr_cpu_pkg::wb_req_t  reg_req_i,
  output qdr_cpu_pkg::wb_data_t reg_dat_o,
  output logic                  reg_ack_o,
  input  logic                  qdr_phy_rdy_i,
  output logic                  qdr_rst_o
);
  import qdr_cpu_pkg::*;

  logic                    access;
  logic                    rst_write;
  logic [6:0]              word_sel;
  logic [RST_CNT_BITS-1:0] stretch_cnt_q;
  logic                    rst_active;
  wb_data_t                rd_word;

  // ack once per request, never two cycles in a row
  assign access    = reg_req_i.cyc & reg_req_i.stb & ~reg_ack_o;
  assign word_sel  = reg_req_i.adr[7:1];
  assign rst_write = access & reg_req_i.we & (word_sel == REG_CTRL) & reg_req_i.dat[0];

  // counter loads with the ack, output follows one cycle later
  assign rst_active = qdr_rst_o | (stretch_cnt_q != '0);

  always_ff @(posedge qdr_clk_i) begin
    if (wb_rst_i) begin
      reg_ack_o     <= 1'b0;
      stretch_cnt_q <= '0;
      qdr_rst_o     <= 1'b0;
    end else begin
      reg_ack_o <= access;
      qdr_rst_o <= (stretch_cnt_q != '0);
      if (rst_write) begin
        stretch_cnt_q <= RST_CNT_BITS'(RESET_STRETCH);
      end else if (stretch_cnt_q != '0) begin
        stretch_cnt_q <= stretch_cnt_q - 1'b1;
      end
    end
  end

  always_comb begin
    rd_word = '0;
    case (word_sel)
      REG_CTRL: begin
        rd_word[0] = qdr_phy_rdy_i;
      end
      REG_STATUS: begin
        rd_word[0] = rst_active;
      end
      default: begin
        rd_word = '0;
      end
    endcase
  end

  // read data registered with the ack, writes return zero
  always_ff @(posedge qdr_clk_i) begin
    if (access) begin
      reg_dat_o <= reg_req_i.we ? '0 : rd_word;
    end
  end

endmodule

/* logic/qdr_mem_window.sv */
// QDR memory access window
// memory-port slave holding the address, byte mask and burst buffers
// software sets a write or read request flag, the burst engine clears it
`timescale 1ns/1ps

module qdr_mem_window (
  input  logic                     qdr_clk_i,
  input  logic                     wb_rst_i,
  input  qdr_cpu_pkg::wb_req_t     mem_req_i,
  output qdr_cpu_pkg::wb_data_t    mem_dat_o,
  output logic                     mem_ack_o,
  output qdr_cpu_pkg::burst_req_t  burst_req_o,
  output logic                     wr_pending_o,
  output logic                     rd_pending_o,
  input  logic                     wr_done_i,
  input  logic                     rd_done_i,
  input  qdr_cpu_pkg::burst_data_t rd_burst_i
);
  import qdr_cpu_pkg::*;

  logic                     access;
  logic                     wr_access;
  logic [6:0]               word_sel;
  wb_data_t                 rd_word;
  qdr_addr_t                addr_q;
  burst_mask_t              mask_q;
  logic [WIN_DATA_BITS-1:0] wr_data_q;
  burst_data_t              rd_data_q;

  assign access    = mem_req_i.cyc & mem_req_i.stb & ~mem_ack_o;
  assign wr_access = access & mem_req_i.we;
  assign word_sel  = mem_req_i.adr[7:1];

  // upper burst bits are not reachable through the window and stay zero
  assign burst_req_o.addr = addr_q;
  assign burst_req_o.data = burst_data_t'(wr_data_q);
  assign burst_req_o.mask = mask_q;

  always_ff @(posedge qdr_clk_i) begin
    if (wb_rst_i) begin
      mem_ack_o    <= 1'b0;
      wr_pending_o <= 1'b0;
      rd_pending_o <= 1'b0;
    end else begin
      mem_ack_o <= access;
      if (wr_done_i) begin
        wr_pending_o <= 1'b0;
      end
      if (rd_done_i) begin
        rd_pending_o <= 1'b0;
      end
      // any value written to a ctrl word raises its request
      if (wr_access && (word_sel == WIN_WR_CTRL)) begin
        wr_pending_o <= 1'b1;
      end
      if (wr_access && (word_sel == WIN_RD_CTRL)) begin
        rd_pending_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge qdr_clk_i) begin
    if (wr_access) begin
      case (word_sel)
        WIN_ADDR_LO: begin
          addr_q[15:0] <= mem_req_i.dat;
        end
        WIN_ADDR_HI: begin
          addr_q[QDR_ADDR_BITS-1:16] <= mem_req_i.dat[ADDR_HI_BITS-1:0];
        end
        WIN_MASK: begin
          mask_q <= mem_req_i.dat[BURST_MASK_BITS-1:0];
        end
        WIN_WR_DATA0: begin
          wr_data_q[15:0] <= mem_req_i.dat;
        end
        WIN_WR_DATA1: begin
          wr_data_q[31:16] <= mem_req_i.dat;
        end
        WIN_WR_DATA2: begin
          wr_data_q[47:32] <= mem_req_i.dat;
        end
        WIN_WR_DATA3: begin
          wr_data_q[WIN_DATA_BITS-1:TOP_WORD_LSB] <= mem_req_i.dat[TOP_WORD_BITS-1:0];
        end
        default: begin
        end
      endcase
    end
    if (rd_done_i) begin
      rd_data_q <= rd_burst_i;
    end
    if (access) begin
      mem_dat_o <= mem_req_i.we ? '0 : rd_word;
    end
  end

  // readback mux, unmapped offsets read zero
  always_comb begin
    rd_word = '0;
    case (word_sel)
      WIN_WR_CTRL:  rd_word = wb_data_t'(wr_pending_o);
      WIN_RD_CTRL:  rd_word = wb_data_t'(rd_pending_o);
      WIN_ADDR_LO:  rd_word = addr_q[15:0];
      WIN_ADDR_HI:  rd_word = wb_data_t'(addr_q[QDR_ADDR_BITS-1:16]);
      WIN_MASK:     rd_word = wb_data_t'(mask_q);
      WIN_WR_DATA0: rd_word = wr_data_q[15:0];
      WIN_WR_DATA1: rd_word = wr_data_q[31:16];
      WIN_WR_DATA2: rd_word = wr_data_q[47:32];
      WIN_WR_DATA3: rd_word = wb_data_t'(wr_data_q[WIN_DATA_BITS-1:TOP_WORD_LSB]);
      WIN_RD_DATA0: rd_word = rd_data_q[15:0];
      WIN_RD_DATA1: rd_word = rd_data_q[31:16];
      WIN_RD_DATA2: rd_word = rd_data_q[47:32];
      WIN_RD_DATA3: rd_word = wb_data_t'(rd_data_q[WIN_DATA_BITS-1:TOP_WORD_LSB]);
      default:      rd_word = '0;
    endcase
  end

endmodule

/* logic/qdr_burst_engine.sv */
// QDR burst engine
// turns a pending window request into one two-beat burst on the
// controller's native write or read port and collects the read beats
`timescale 1ns/1ps

module qdr_burst_engine (
  input  logic                     qdr_clk_i,
  input  logic                     wb_rst_i,
  input  qdr_cpu_pkg::burst_req_t  burst_req_i,
  input  logic                     wr_pending_i,
  input  logic                     rd_pending_i,
  output logic                     wr_done_o,
  output logic                     rd_done_o,
  output qdr_cpu_pkg::burst_data_t rd_burst_o,
  output qdr_cpu_pkg::qdr_wr_cmd_t qdr_wr_o,
  input  logic                     qdr_wr_full_i,
  output qdr_cpu_pkg::qdr_rd_cmd_t qdr_rd_o,
  input  qdr_cpu_pkg::qdr_beat_t   qdr_rd_data_i,
  input  logic                     qdr_rd_valid_i,
  input  logic                     qdr_rd_full_i
);
  import qdr_cpu_pkg::*;

  burst_state_t state_q;
  logic         rd_beat_q;
  logic         beat_hi;

  assign beat_hi   = (state_q == WR_BEAT1);
  assign wr_done_o = beat_hi;

  always_ff @(posedge qdr_clk_i) begin
    if (wb_rst_i) begin
      state_q   <= IDLE;
      rd_beat_q <= 1'b0;
      rd_done_o <= 1'b0;
    end else begin
      rd_done_o <= 1'b0;
      case (state_q)
        IDLE: begin
          // read flag is still set while rd_done is high, so hold off then
          if (wr_pending_i && !qdr_wr_full_i) begin
            state_q <= WR_BEAT0;
          end else if (rd_pending_i && !wr_pending_i && !qdr_rd_full_i && !rd_done_o) begin
            state_q   <= RD_ISSUE;
            rd_beat_q <= 1'b0;
          end
        end
        WR_BEAT0: state_q <= WR_BEAT1;
        WR_BEAT1: state_q <= IDLE;
        RD_ISSUE: state_q <= RD_WAIT;
        RD_WAIT: begin
          if (qdr_rd_valid_i) begin
            rd_beat_q <= ~rd_beat_q;
            if (rd_beat_q) begin
              state_q   <= IDLE;
              rd_done_o <= 1'b1;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // first beat carries words 0-1, second words 2-3
  always_ff @(posedge qdr_clk_i) begin
    if ((state_q == RD_WAIT) && qdr_rd_valid_i) begin
      if (!rd_beat_q) begin
        rd_burst_o[BEAT_BITS-1:0] <= qdr_rd_data_i;
      end else begin
        rd_burst_o[BURST_BITS-1:BEAT_BITS] <= qdr_rd_data_i;
      end
    end
  end

  always_comb begin
    qdr_wr_o.addr    = burst_req_i.addr;
    qdr_wr_o.data    = beat_hi ? burst_req_i.data[BURST_BITS-1:BEAT_BITS]
                               : burst_req_i.data[BEAT_BITS-1:0];
    qdr_wr_o.be      = beat_hi ? burst_req_i.mask[BURST_MASK_BITS-1:BEAT_BE_BITS]
                               : burst_req_i.mask[BEAT_BE_BITS-1:0];
    qdr_wr_o.addr_en = (state_q == WR_BEAT0);
    qdr_wr_o.data_en = (state_q == WR_BEAT0) || (state_q == WR_BEAT1);
    qdr_rd_o.addr    = burst_req_i.addr;
    qdr_rd_o.en      = (state_q == RD_ISSUE);
  end

endmodule

/* logic/qdr_cpu_top.sv */
// QDR CPU access top level
// register port for PHY reset and status, memory port for indirect
// burst access through the window and the burst engine
`timescale 1ns/1ps

module qdr_cpu_top (
  input  logic                     qdr_clk_i,
  input  logic                     wb_rst_i,
  input  qdr_cpu_pkg::wb_req_t     reg_req_i,
  output qdr_cpu_pkg::wb_data_t    reg_dat_o,
  output logic                     reg_ack_o,
  input  qdr_cpu_pkg::wb_req_t     mem_req_i,
  output qdr_cpu_pkg::wb_data_t    mem_dat_o,
  output logic                     mem_ack_o,
  output logic                     qdr_rst_o,
  input  logic                     qdr_phy_rdy_i,
  output qdr_cpu_pkg::qdr_wr_cmd_t qdr_wr_o,
  input  logic                     qdr_wr_full_i,
  output qdr_cpu_pkg::qdr_rd_cmd_t qdr_rd_o,
  input  qdr_cpu_pkg::qdr_beat_t   qdr_rd_data_i,
  input  logic                     qdr_rd_valid_i,
  input  logic                     qdr_rd_full_i
);
  import qdr_cpu_pkg::*;

  burst_req_t  burst_req;
  logic        wr_pending;
  logic        rd_pending;
  logic        wr_done;
  logic        rd_done;
  burst_data_t rd_burst;

  qdr_reset_ctrl qdr_reset_ctrl_inst (
    .qdr_clk_i     (qdr_clk_i),
    .wb_rst_i      (wb_rst_i),
    .reg_req_i     (reg_req_i),
    .reg_dat_o     (reg_dat_o),
    .reg_ack_o     (reg_ack_o),
    .qdr_phy_rdy_i (qdr_phy_rdy_i),
    .qdr_rst_o     (qdr_rst_o)
  );

  qdr_mem_window qdr_mem_window_inst (
    .qdr_clk_i    (qdr_clk_i),
    .wb_rst_i     (wb_rst_i),
    .mem_req_i    (mem_req_i),
    .mem_dat_o    (mem_dat_o),
    .mem_ack_o    (mem_ack_o),
    .burst_req_o  (burst_req),
    .wr_pending_o (wr_pending),
    .rd_pending_o (rd_pending),
    .wr_done_i    (wr_done),
    .rd_done_i    (rd_done),
    .rd_burst_i   (rd_burst)
  );

  qdr_burst_engine qdr_burst_engine_inst (
    .qdr_clk_i      (qdr_clk_i),
    .wb_rst_i       (wb_rst_i),
    .burst_req_i    (burst_req),
    .wr_pending_i   (wr_pending),
    .rd_pending_i   (rd_pending),
    .wr_done_o      (wr_done),
    .rd_done_o      (rd_done),
    .rd_burst_o     (rd_burst),
    .qdr_wr_o       (qdr_wr_o),
    .qdr_wr_full_i  (qdr_wr_full_i),
    .qdr_rd_o       (qdr_rd_o),
    .qdr_rd_data_i  (qdr_rd_data_i),
    .qdr_rd_valid_i (qdr_rd_valid_i),
    .qdr_rd_full_i  (qdr_rd_full_i)
  );

endmodule

/* tb/tb_clk_gen.sv */
// testbench clock source
// free-running clock that starts low at time zero
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk_o
);
  initial clk_o = 1'b0;
  always #(PERIOD_NS / 2.0) clk_o = ~clk_o;
endmodule

/* tb/qdr_sram_model.sv */
// QDR controller port model
// keeps whole bursts per address with 9-bit byte lanes, returns two read
// beats after a fixed latency and holds phy ready low around a PHY reset
`timescale 1ns/1ps

module qdr_sram_model (
  input  logic                     clk_i,
  input  logic                     qdr_rst_i,
  output logic                     qdr_phy_rdy_o,
  input  qdr_cpu_pkg::qdr_wr_cmd_t qdr_wr_i,
  input  qdr_cpu_pkg::qdr_rd_cmd_t qdr_rd_i,
  output qdr_cpu_pkg::qdr_beat_t   qdr_rd_data_o,
  output logic                     qdr_rd_valid_o
);
  import qdr_cpu_pkg::*;

  localparam int RD_LATENCY = 3;

  logic [71:0] mem [qdr_addr_t];
  logic [71:0] word;
  qdr_addr_t   wr_addr  = '0;
  qdr_addr_t   rd_addr  = '0;
  int          rd_cnt   = 0;
  int          rdy_hold = 0;
  logic        rdy_next = 1'b1;

  initial begin
    qdr_phy_rdy_o  = 1'b1;
    qdr_rd_valid_o = 1'b0;
    qdr_rd_data_o  = '0;
  end

  always @(posedge clk_i) begin
    // beat 0 comes with the address, beat 1 goes to the upper half
    if (qdr_wr_i.data_en) begin
      if (qdr_wr_i.addr_en) wr_addr = qdr_wr_i.addr;
      word = mem.exists(wr_addr) ? mem[wr_addr] : '0;
      for (int i = 0; i < 4; i++) begin
        if (qdr_wr_i.be[i] && qdr_wr_i.addr_en) word[9*i +: 9] = qdr_wr_i.data[9*i +: 9];
        if (qdr_wr_i.be[i] && !qdr_wr_i.addr_en) word[36 + 9*i +: 9] = qdr_wr_i.data[9*i +: 9];
      end
      mem[wr_addr] = word;
    end
    if (qdr_rd_i.en) begin
      rd_addr = qdr_rd_i.addr;
      rd_cnt  = 1;
    end else if (rd_cnt != 0) begin
      rd_cnt = (rd_cnt == RD_LATENCY + 1) ? 0 : rd_cnt + 1;
    end
    // ready stays low for 4 cycles after the reset falls
    if (qdr_rst_i) begin
      rdy_hold = 4;
      rdy_next = 1'b0;
    end else if (rdy_hold != 0) begin
      rdy_hold = rdy_hold - 1;
      rdy_next = 1'b0;
    end else begin
      rdy_next = 1'b1;
    end
    #1;
    word = '0;
    if (rd_cnt >= RD_LATENCY && mem.exists(rd_addr)) word = mem[rd_addr];
    qdr_rd_valid_o = (rd_cnt >= RD_LATENCY);
    qdr_rd_data_o  = (rd_cnt == RD_LATENCY) ? word[35:0] : word[71:36];
    qdr_phy_rdy_o  = rdy_next;
  end

endmodule

/* tb/tb_qdr_cpu_top.sv */
// QDR CPU access testbench
// runs table bursts through the memory window with and without
// back-pressure, checks window readback and the PHY reset pulse
`timescale 1ns/1ps

module tb_qdr_cpu_top;
  import qdr_cpu_pkg::*;

  localparam int BUS_TIMEOUT  = 20;
  localparam int POLL_TIMEOUT = 100;
  localparam int N_ENTRIES    = 6;

  logic        qdr_clk_i;
  logic        wb_rst_i;
  wb_req_t     reg_req_i;
  wb_req_t     mem_req_i;
  wb_data_t    reg_dat_o;
  wb_data_t    mem_dat_o;
  logic        reg_ack_o;
  logic        mem_ack_o;
  logic        qdr_rst_o;
  logic        qdr_phy_rdy_i;
  qdr_wr_cmd_t qdr_wr_o;
  qdr_rd_cmd_t qdr_rd_o;
  qdr_beat_t   qdr_rd_data_i;
  logic        qdr_rd_valid_i;
  logic        qdr_wr_full_i = 1'b0;
  logic        qdr_rd_full_i = 1'b0;
  logic        random_full   = 1'b0;
  logic [15:0] lfsr          = 16'd91;
  logic        addr_en_q     = 1'b0;
  logic        rd_en_q       = 1'b0;
  logic        wr_full_q     = 1'b0;
  logic        rd_full_q     = 1'b0;
  int          errors        = 0;
  int          checks        = 0;
  int          run_len       = 0;
  int          pulse_len     = 0;
  wb_data_t    rdata;
  burst_data_t expect_mem [qdr_addr_t];

  // address, write data and byte mask, repeated addresses merge lanes
  qdr_addr_t   tbl_addr [N_ENTRIES] = '{22'h000010, 22'h3f0abc, 22'h000010,
                                        22'h155555, 22'h3f0abc, 22'h2aaaaa};
  burst_data_t tbl_data [N_ENTRIES] = '{72'h123456789abcdef012, 72'hfedcba987654321fed,
                                        72'h0f1e2d3c4b5a697887, 72'haaaa5555aaaa5555aa,
                                        72'h13579bdf02468ace11, 72'hffffffffffffffffff};
  burst_mask_t tbl_mask [N_ENTRIES] = '{8'hff, 8'h0f, 8'ha5, 8'hff, 8'h3c, 8'h81};

  tb_clk_gen #(.PERIOD_NS(8.0)) clk_gen_inst (.clk_o(qdr_clk_i));

  qdr_cpu_top qdr_cpu_top_inst (.*);

  qdr_sram_model sram_model_inst (
    .clk_i          (qdr_clk_i),
    .qdr_rst_i      (qdr_rst_o),
    .qdr_phy_rdy_o  (qdr_phy_rdy_i),
    .qdr_wr_i       (qdr_wr_o),
    .qdr_rd_i       (qdr_rd_o),
    .qdr_rd_data_o  (qdr_rd_data_i),
    .qdr_rd_valid_o (qdr_rd_valid_i)
  );

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic abort_run(input string why);
    $display("timeout at %0t: %s", $time, why);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("Verification failed");
    $finish;
  endtask

  // one access on either port, entered and left 1 ns after a clock edge
  task automatic bus_xfer(input logic to_mem, input logic we, input logic [6:0] word,
                          input wb_data_t wdata, output wb_data_t rd);
    wb_req_t req;
    logic    got;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.sel = 2'b11;
    req.adr = {24'd0, word, 1'b0};
    req.dat = wdata;
    got     = 1'b0;
    if (to_mem) mem_req_i = req;
    else reg_req_i = req;
    for (int n = 0; n < BUS_TIMEOUT && !got; n++) begin
      @(posedge qdr_clk_i);
      #1;
      got = to_mem ? mem_ack_o : reg_ack_o;
    end
    mem_req_i = '0;
    reg_req_i = '0;
    rd = to_mem ? mem_dat_o : reg_dat_o;
    if (!got) abort_run("bus slave gave no ack");
  endtask

  task automatic poll_flag(input logic to_mem, input logic [6:0] word, input logic want);
    wb_data_t d;
    d = '0;
    for (int n = 0; n < POLL_TIMEOUT; n++) begin
      bus_xfer(to_mem, 1'b0, word, 16'h0, d);
      if (d[0] === want) break;
    end
    if (d[0] !== want) abort_run("status bit never reached the expected value");
  endtask

  task automatic write_readback(input logic [6:0] word, input wb_data_t wdata,
                                input wb_data_t want);
    wb_data_t d;
    bus_xfer(1'b1, 1'b1, word, wdata, d);
    bus_xfer(1'b1, 1'b0, word, 16'h0, d);
    check_value($sformatf("window word %0d", word), d, want);
  endtask

  task automatic run_burst(input int i);
    burst_data_t wdata;
    burst_data_t want;
    wb_data_t    d;
    // only 56 data bits are reachable through the window
    wdata = tbl_data[i];
    wdata[71:56] = '0;
    want = expect_mem.exists(tbl_addr[i]) ? expect_mem[tbl_addr[i]] : '0;
    for (int k = 0; k < 8; k++) begin
      if (tbl_mask[i][k]) want[9*k +: 9] = wdata[9*k +: 9];
    end
    expect_mem[tbl_addr[i]] = want;
    bus_xfer(1'b1, 1'b1, WIN_ADDR_LO, tbl_addr[i][15:0], d);
    bus_xfer(1'b1, 1'b1, WIN_ADDR_HI, wb_data_t'(tbl_addr[i][21:16]), d);
    bus_xfer(1'b1, 1'b1, WIN_MASK, wb_data_t'(tbl_mask[i]), d);
    for (int w = 0; w < 4; w++) begin
      bus_xfer(1'b1, 1'b1, 7'(WIN_WR_DATA0 + w), wdata[16*w +: 16], d);
    end
    bus_xfer(1'b1, 1'b1, WIN_WR_CTRL, 16'h1, d);
    poll_flag(1'b1, WIN_WR_CTRL, 1'b0);
    bus_xfer(1'b1, 1'b1, WIN_RD_CTRL, 16'h1, d);
    poll_flag(1'b1, WIN_RD_CTRL, 1'b0);
    for (int w = 0; w < 4; w++) begin
      bus_xfer(1'b1, 1'b0, 7'(WIN_RD_DATA0 + w), 16'h0, d);
      check_value($sformatf("entry %0d read word %0d", i, w), d,
                  want[16*w +: 16] & ((w == 3) ? 16'h00ff : 16'hffff));
    end
  endtask

  // back-pressure, one LFSR step per flag bit
  always @(posedge qdr_clk_i) begin
    #1;
    if (random_full) begin
      lfsr = lfsr_step(lfsr);
      qdr_wr_full_i = lfsr[0];
      lfsr = lfsr_step(lfsr);
      qdr_rd_full_i = lfsr[0];
    end else begin
      qdr_wr_full_i = 1'b0;
      qdr_rd_full_i = 1'b0;
    end
  end

  // a burst may only start after a cycle with its full flag low
  always @(posedge qdr_clk_i) begin
    if (qdr_wr_o.addr_en && !addr_en_q && wr_full_q) begin
      errors++;
      $display("** Error at %0t: write burst started while wr_full was high", $time);
    end
    if (qdr_rd_o.en && !rd_en_q && rd_full_q) begin
      errors++;
      $display("** Error at %0t: read burst started while rd_full was high", $time);
    end
    addr_en_q <= qdr_wr_o.addr_en;
    rd_en_q   <= qdr_rd_o.en;
    wr_full_q <= qdr_wr_full_i;
    rd_full_q <= qdr_rd_full_i;
    if (qdr_rst_o) begin
      run_len <= run_len + 1;
    end else if (run_len != 0) begin
      pulse_len <= run_len;
      run_len   <= 0;
    end
  end

  initial begin
    reg_req_i = '0;
    mem_req_i = '0;
    wb_rst_i  = 1'b1;
    repeat (3) @(posedge qdr_clk_i);
    #1;
    wb_rst_i = 1'b0;
    check_value("outputs after reset", {reg_ack_o, mem_ack_o, qdr_rst_o,
                qdr_wr_o.addr_en, qdr_wr_o.data_en, qdr_rd_o.en}, '0);
    bus_xfer(1'b1, 1'b0, WIN_WR_CTRL, 16'h0, rdata);
    check_value("WIN_WR_CTRL after reset", rdata, '0);
    bus_xfer(1'b1, 1'b0, WIN_RD_CTRL, 16'h0, rdata);
    check_value("WIN_RD_CTRL after reset", rdata, '0);
    bus_xfer(1'b0, 1'b0, REG_STATUS, 16'h0, rdata);
    check_value("REG_STATUS after reset", rdata, '0);

    write_readback(WIN_ADDR_LO, 16'hbeef, 16'hbeef);
    write_readback(WIN_ADDR_HI, 16'hffff, 16'h003f);
    write_readback(WIN_MASK, 16'h1234, 16'h0034);
    write_readback(WIN_WR_DATA0, 16'ha5a5, 16'ha5a5);
    write_readback(WIN_WR_DATA1, 16'h5a5a, 16'h5a5a);
    write_readback(WIN_WR_DATA2, 16'hc3c3, 16'hc3c3);
    write_readback(WIN_WR_DATA3, 16'habcd, 16'h00cd);

    for (int i = 0; i < N_ENTRIES; i++) run_burst(i);
    random_full = 1'b1;
    for (int i = 0; i < N_ENTRIES; i++) run_burst(i);
    random_full = 1'b0;

    // PHY reset pulse, then ready drops and comes back
    bus_xfer(1'b0, 1'b1, REG_CTRL, 16'h1, rdata);
    bus_xfer(1'b0, 1'b0, REG_STATUS, 16'h0, rdata);
    check_value("REG_STATUS during reset pulse", rdata, 16'h1);
    poll_flag(1'b0, REG_CTRL, 1'b0);
    poll_flag(1'b0, REG_CTRL, 1'b1);
    check_value("PHY reset pulse length", pulse_len, RESET_STRETCH);
    bus_xfer(1'b0, 1'b0, REG_STATUS, 16'h0, rdata);
    check_value("REG_STATUS after reset pulse", rdata, '0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* qdr_cpu.f */
logic/qdr_cpu_pkg.sv
logic/qdr_reset_ctrl.sv
logic/qdr_mem_window.sv
logic/qdr_burst_engine.sv
logic/qdr_cpu_top.sv
tb/tb_clk_gen.sv
tb/qdr_sram_model.sv
tb/tb_qdr_cpu_top.sv
